/* sim.f */
+incdir+dv
hdl/arithPkg.sv
hdl/intervalIf.sv
hdl/freqModel.sv
hdl/seqDivider.sv
hdl/intervalUpdate.sv
hdl/renormalizer.sv
hdl/wordPacker.sv
hdl/arithEncoder.sv
dv/arithEncoder_properties.sv
dv/tbArithEncoder.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tbArithEncoder
RTL_TOP ?= arithEncoder
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
SIM_ARGS ?= +verilator+error+limit+100
PASS_TEXT ?= sim passed
RTL_FILES ?= $(shell grep '^hdl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)

/* dv/encoderModel.svh */
// reference model of the arithmetic encoding rule with LSB-first word packing
`ifndef ENCODER_MODEL_SVH
`define ENCODER_MODEL_SVH

bit modelBits[$];                       // emitted bit stream in order
logic [WORD_WIDTH-1:0] expWords[$];
int expBytes[$];                        // validBytes expected with each word

function automatic void emitBit(input bit value, inout int pending);
    modelBits.push_back(value);
    for (int i = 0; i < pending; i++) begin
        modelBits.push_back(!value);    // deferred bits take the complement
    end
    pending = 0;
endfunction

function automatic void packWords();
    logic [WORD_WIDTH-1:0] wordBits;
    int fill;
    wordBits = '0;
    fill = 0;
    expWords.delete();
    expBytes.delete();
    foreach (modelBits[i]) begin
        wordBits[fill] = modelBits[i];
        fill++;
        if (fill == WORD_WIDTH) begin
            expWords.push_back(wordBits);
            expBytes.push_back(WORD_WIDTH / 8);
            wordBits = '0;
            fill = 0;
        end
    end
    if (fill != 0) begin                // short last word, bytes rounded up
        expWords.push_back(wordBits);
        expBytes.push_back((fill + 7) / 8);
    end
endfunction

function automatic void encodeStream(input int syms[$]);
    longint low;
    longint high;
    longint span;
    longint half;
    longint quarter;
    int pending;
    bit scaling;
    half = longint'(arithPkg::HALF);
    quarter = longint'(arithPkg::QUARTER);
    low = 0;
    high = longint'(arithPkg::WHOLE);
    pending = 0;
    modelBits.delete();
    foreach (syms[i]) begin
        span = high - low;
        high = low + span * longint'(arithPkg::CUM_FREQ[syms[i] + 1])
            / longint'(arithPkg::TOTAL_FREQ);
        low = low + span * longint'(arithPkg::CUM_FREQ[syms[i]])
            / longint'(arithPkg::TOTAL_FREQ);
        scaling = 1'b1;
        while (scaling) begin
            if (high < half) begin
                emitBit(1'b0, pending);
                low = 2 * low;
                high = 2 * high;
            end else if (low > half) begin
                emitBit(1'b1, pending);
                low = 2 * (low - half);
                high = 2 * (high - half);
            end else if (low > quarter && high < 3 * quarter) begin
                pending++;                  // straddles the middle
                low = 2 * (low - quarter);
                high = 2 * (high - quarter);
            end else begin
                scaling = 1'b0;
            end
        end
    end
    pending++;                              // final quarter needs one extra bit
    emitBit(low > quarter, pending);
    packWords();
endfunction

`endif

/* dv/tbArithEncoder.sv */
// testbench for the arithmetic encoder, compares output words with a reference model
`timescale 1ns/1ns
`default_nettype none

module tbArithEncoder;

    localparam int WORD_WIDTH = 32;
    localparam int BYTE_BITS = $clog2(WORD_WIDTH / 8) + 1;
    localparam int WAIT_TIMEOUT = 2000;     // cycles per wait
    localparam int MAX_DELAY = 5;
    localparam int PENDING_LENGTH = 40;
    localparam int RANDOM_LENGTH = 200;
    localparam int RESTART_LENGTH = 60;

    logic clk;
    logic rstn;
    logic start;
    logic idle;
    logic symbolReq;
    logic symbolAck;
    arithPkg::symbol_t symbol;
    logic wordReady;
    logic wordAck;
    logic [WORD_WIDTH-1:0] word;
    logic [BYTE_BITS-1:0] validBytes;

    int seed;
    int eofStream[$];
    int pendingStream[$];
    int randomStream[$];
    int restartStream[$];

    `include "encoderModel.svh"

    arithEncoder #(
        .WORD_WIDTH(WORD_WIDTH)
    ) i_arithEncoder (
        .clk,
        .rstn,
        .start,
        .idle,
        .symbolReq,
        .symbolAck,
        .symbol,
        .wordReady,
        .wordAck,
        .word,
        .validBytes
    );

    always #5 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("sim failed");
        $fatal(1, "%s", reason);
    endtask

    // bound handshake assertions count their failures
    always @(posedge clk) begin
        if (i_arithEncoder.i_arithEncoderProperties.failCount != 0) begin
            abortRun("a handshake assertion failed");
        end
    end

    function automatic int randomDelay(input bit enabled);
        if (!enabled) begin
            return 0;
        end
        return int'($unsigned($random(seed)) % (MAX_DELAY + 1));
    endfunction

    task automatic waitSymbolReq(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_TIMEOUT) begin
                abortRun($sformatf("symbol handshake hung waiting for symbolReq=%b", level));
            end
        end while (symbolReq !== level);
    endtask

    task automatic waitWordReady(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_TIMEOUT) begin
                abortRun($sformatf("word handshake hung waiting for wordReady=%b", level));
            end
        end while (wordReady !== level);
    endtask

    task automatic waitIdle(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_TIMEOUT) begin
                abortRun({name, ": idle never rose after the last word"});
            end
        end while (idle !== 1'b1);
    endtask

    task automatic checkResetState();
        repeat (10) begin
            @(posedge clk);
            assert (idle === 1'b1 && symbolReq === 1'b0 && wordReady === 1'b0) else begin
                $display("Fail resetState: idle,symbolReq,wordReady expected 100 actual %b%b%b",
                    idle, symbolReq, wordReady);
                abortRun("outputs wrong after reset");
            end
        end
    endtask

    task automatic checkWord(input string name, input int idx);
        assert (word === expWords[idx]) else begin
            $display("Fail %s: word %0d expected %h actual %h", name, idx, expWords[idx], word);
            abortRun("output word mismatch");
        end
        assert (validBytes === BYTE_BITS'(expBytes[idx])) else begin
            $display("Fail %s: validBytes of word %0d expected %0d actual %0d",
                name, idx, expBytes[idx], validBytes);
            abortRun("validBytes mismatch");
        end
    endtask

    task automatic feedSymbols(input int syms[$], input int ackDelay[$], input int relDelay[$]);
        foreach (syms[i]) begin
            waitSymbolReq(1'b1);
            repeat (ackDelay[i]) @(posedge clk);
            symbol <= arithPkg::symbol_t'(syms[i]);
            symbolAck <= 1'b1;
            waitSymbolReq(1'b0);
            repeat (relDelay[i]) @(posedge clk);
            symbolAck <= 1'b0;
        end
    endtask

    task automatic collectWords(input string name, input int ackDelay[$], input int relDelay[$]);
        foreach (expWords[i]) begin
            waitWordReady(1'b1);
            checkWord(name, i);             // word is stable while wordReady is high
            repeat (ackDelay[i]) @(posedge clk);
            wordAck <= 1'b1;
            waitWordReady(1'b0);
            repeat (relDelay[i]) @(posedge clk);
            wordAck <= 1'b0;
        end
    endtask

    task automatic runStream(input string name, input int syms[$], input bit withDelays);
        int symAckDelay[$];
        int symRelDelay[$];
        int wordAckDelay[$];
        int wordRelDelay[$];
        encodeStream(syms);
        // delays drawn up front so both responders see a fixed sequence
        foreach (syms[i]) begin
            symAckDelay.push_back(randomDelay(withDelays));
            symRelDelay.push_back(randomDelay(withDelays));
        end
        foreach (expWords[i]) begin
            wordAckDelay.push_back(randomDelay(withDelays));
            wordRelDelay.push_back(randomDelay(withDelays));
        end
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        fork
            feedSymbols(syms, symAckDelay, symRelDelay);
            collectWords(name, wordAckDelay, wordRelDelay);
        join
        waitIdle(name);
    endtask

    initial begin
        seed = 32'h06df168b;
        clk = 1'b0;
        rstn <= 1'b0;
        start <= 1'b0;
        symbolAck <= 1'b0;
        symbol <= '0;
        wordAck <= 1'b0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        checkResetState();

        eofStream.push_back(arithPkg::EOF_SYMBOL);
        runStream("eofOnly", eofStream, 1'b0);

        repeat (PENDING_LENGTH) pendingStream.push_back(1);    // straddles HALF
        pendingStream.push_back(arithPkg::EOF_SYMBOL);
        runStream("pendingRun", pendingStream, 1'b0);

        repeat (RANDOM_LENGTH - 1) begin
            randomStream.push_back(int'($unsigned($random(seed)) % arithPkg::EOF_SYMBOL));
        end
        randomStream.push_back(arithPkg::EOF_SYMBOL);
        runStream("randomStream", randomStream, 1'b0);
        assert (expWords.size() > 4) else begin
            abortRun("random stream did not span several full words");
        end
        runStream("backPressure", randomStream, 1'b1);

        repeat (RESTART_LENGTH - 1) begin
            restartStream.push_back(int'($unsigned($random(seed)) % arithPkg::EOF_SYMBOL));
        end
        restartStream.push_back(arithPkg::EOF_SYMBOL);
        runStream("restart", restartStream, 1'b1);

        repeat (5) @(posedge clk);
        if (i_arithEncoder.i_arithEncoderProperties.failCount == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            abortRun("a handshake assertion failed");
        end
    end

endmodule

`default_nettype wire

/* dv/arithEncoder_properties.sv */
// handshake assertions on the arithmetic encoder top level
`timescale 1ns/1ns
`default_nettype none

module arithEncoderProperties #(
    parameter int WORD_WIDTH = 32
) (
    input wire clk,
    input wire rstn,
    input wire idle,
    input wire symbolReq,
    input wire symbolAck,
    input wire wordReady,
    input wire wordAck,
    input wire [$clog2(WORD_WIDTH/8):0] validBytes
);

    int failCount = 0;      // read by the testbench

    symbolReqHolds: assert property (@(posedge clk) disable iff (!rstn)
        symbolReq && !symbolAck |=> symbolReq)
        else begin
            failCount++;
            $error("symbolReq dropped before symbolAck");
        end

    wordReadyHolds: assert property (@(posedge clk) disable iff (!rstn)
        wordReady && !wordAck |=> wordReady)
        else begin
            failCount++;
            $error("wordReady dropped before wordAck");
        end

    validBytesRange: assert property (@(posedge clk) disable iff (!rstn)
        wordReady |-> (validBytes >= 1) && (validBytes <= WORD_WIDTH / 8))
        else begin
            failCount++;
            $error("validBytes out of range");
        end

    idleNotReady: assert property (@(posedge clk) disable iff (!rstn)
        !(idle && wordReady))
        else begin
            failCount++;
            $error("idle and wordReady high together");
        end

endmodule

bind arithEncoder arithEncoderProperties #(
    .WORD_WIDTH(WORD_WIDTH)
) i_arithEncoderProperties (
    .clk(clk),
    .rstn(rstn),
    .idle(idle),
    .symbolReq(symbolReq),
    .symbolAck(symbolAck),
    .wordReady(wordReady),
    .wordAck(wordAck),
    .validBytes(validBytes)
);

`default_nettype wire

/* hdl/arithEncoder.sv */
// arithmetic encoder top with symbol request handshake and start/idle control
`timescale 1ns/1ns
`default_nettype none

module arithEncoder #(
    parameter int WORD_WIDTH = 32
) (
    input wire clk,
    input wire rstn,
    input wire start,
    output logic idle,
    output logic symbolReq,
    input wire symbolAck,
    input wire arithPkg::symbol_t symbol,
    output logic wordReady,
    input wire wordAck,
    output logic [WORD_WIDTH-1:0] word,
    output logic [$clog2(WORD_WIDTH/8):0] validBytes
);

    typedef enum logic [1:0] {IDLE, RUN, REQUEST, RELEASE} ctrl_t;

    ctrl_t ctrl;
    arithPkg::symbol_t symbolHeld;
    logic symbolTaken;
    logic needSymbol;
    logic finished;
    logic bitValid;
    logic bitValue;
    logic flush;
    logic bitStall;

    intervalIf ivBus ();

    assign idle = ctrl == IDLE;
    assign symbolReq = ctrl == REQUEST;
    assign symbolTaken = (ctrl == RELEASE) && !symbolAck;  // only once ack is back low

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ctrl <= IDLE;
        end else begin
            case (ctrl)
                IDLE: begin
                    if (start) begin
                        ctrl <= RUN;
                    end
                end
                RUN: begin
                    if (finished) begin
                        ctrl <= IDLE;
                    end else if (needSymbol) begin
                        ctrl <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (symbolAck) begin
                        symbolHeld <= symbol;
                        ctrl <= RELEASE;
                    end
                end
                default: begin
                    if (!symbolAck) begin
                        ctrl <= RUN;
                    end
                end
            endcase
        end
    end

    intervalUpdate i_intervalUpdate (
        .clk,
        .rstn,
        .bus(ivBus.upd)
    );

    renormalizer i_renormalizer (
        .clk,
        .rstn,
        .bus(ivBus.ren),
        .symbolIn(symbolHeld),
        .symbolTaken,
        .needSymbol,
        .finished,
        .bitValid,
        .bitValue,
        .flush,
        .bitStall
    );

    wordPacker #(
        .WORD_WIDTH(WORD_WIDTH)
    ) i_wordPacker (
        .clk,
        .rstn,
        .bitValid,
        .bitValue,
        .flush,
        .bitStall,
        .wordReady,
        .wordAck,
        .word,
        .validBytes
    );

endmodule

`default_nettype wire

/* hdl/wordPacker.sv */
// packs bits LSB first into words and hands each out over a four-phase handshake
`timescale 1ns/1ns
`default_nettype none

module wordPacker #(
    parameter int WORD_WIDTH = 32
) (
    input wire clk,
    input wire rstn,
    input wire bitValid,
    input wire bitValue,
    input wire flush,
    output logic bitStall,
    output logic wordReady,
    input wire wordAck,
    output logic [WORD_WIDTH-1:0] word,
    output logic [$clog2(WORD_WIDTH/8):0] validBytes
);

    localparam int FILL_BITS = $clog2(WORD_WIDTH);
    localparam int BYTE_BITS = $clog2(WORD_WIDTH / 8) + 1;

    typedef enum logic [1:0] {COLLECT, WAIT_ACK, WAIT_RELEASE} state_t;

    state_t state;
    logic [FILL_BITS-1:0] fill;     // index of the next bit

    assign bitStall = state != COLLECT;
    assign wordReady = state == WAIT_ACK;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= COLLECT;
            fill <= '0;
            word <= '0;
        end else begin
            case (state)
                COLLECT: begin
                    if (bitValid) begin
                        word[fill] <= bitValue;
                        if (flush || fill == FILL_BITS'(WORD_WIDTH - 1)) begin
                            validBytes <= BYTE_BITS'(fill >> 3) + 1'b1;   // bytes touched
                            fill <= '0;
                            state <= WAIT_ACK;
                        end else begin
                            fill <= fill + 1'b1;
                        end
                    end
                end
                WAIT_ACK: begin
                    if (wordAck) begin
                        word <= '0;     // unused bits of a short word read as zero
                        state <= WAIT_RELEASE;
                    end
                end
                default: begin
                    if (!wordAck) begin
                        state <= COLLECT;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/renormalizer.sv */
// interval scaling FSM with pending-bit tracking and end-of-stream flush
`timescale 1ns/1ns
`default_nettype none

module renormalizer (
    input wire clk,
    input wire rstn,
    intervalIf.ren bus,
    input wire arithPkg::symbol_t symbolIn,
    input wire symbolTaken,
    output logic needSymbol,
    output logic finished,
    output logic bitValid,
    output logic bitValue,
    output logic flush,
    input wire bitStall
);

    typedef enum logic [2:0] {
        NEED_SYMBOL,
        UPDATE,
        SCALE,
        EMIT_PENDING,
        EMIT_FINAL,
        DRAIN
    } state_t;

    state_t state;
    arithPkg::bound_t low;
    arithPkg::bound_t high;
    arithPkg::symbol_t curSymbol;
    logic [arithPkg::PENDING_BITS-1:0] pending;
    logic pendingValue;         // complement of the last emitted bit
    logic lastSymbol;
    logic flushing;
    logic lowerHalf;
    logic upperHalf;
    logic middleHalf;
    logic accept;

    assign bus.curLow = low;
    assign bus.curHigh = high;
    assign bus.symbol = curSymbol;

    always_comb begin
        lowerHalf = high < arithPkg::HALF;
        upperHalf = low > arithPkg::HALF;
        middleHalf = (low > arithPkg::QUARTER) && (high < arithPkg::THREE_QUARTERS);
        bitValid = 1'b0;
        bitValue = 1'b0;
        case (state)
            SCALE: begin
                bitValid = lowerHalf || upperHalf;
                bitValue = !lowerHalf;
            end
            EMIT_FINAL: begin
                bitValid = 1'b1;
                bitValue = low > arithPkg::QUARTER;
            end
            EMIT_PENDING: begin
                bitValid = 1'b1;
                bitValue = pendingValue;
            end
            default: bitValid = 1'b0;
        endcase
    end

    assign accept = bitValid && !bitStall;
    assign flush = (state == EMIT_PENDING) && flushing && (pending == 1);
    assign needSymbol = state == NEED_SYMBOL;
    assign finished = (state == DRAIN) && !bitStall;    // last word handed out

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= NEED_SYMBOL;
            low <= '0;
            high <= arithPkg::WHOLE;
            pending <= '0;
            lastSymbol <= 1'b0;
            flushing <= 1'b0;
            bus.go <= 1'b0;
        end else begin
            bus.go <= 1'b0;
            case (state)
                NEED_SYMBOL: begin
                    if (symbolTaken) begin
                        curSymbol <= symbolIn;
                        lastSymbol <= symbolIn == arithPkg::EOF_SYMBOL;
                        bus.go <= 1'b1;
                        state <= UPDATE;
                    end
                end
                UPDATE: begin
                    if (bus.done) begin
                        low <= bus.low;
                        high <= bus.high;
                        state <= SCALE;
                    end
                end
                SCALE: begin
                    if (lowerHalf || upperHalf) begin
                        if (accept) begin
                            low <= lowerHalf ? low << 1 : (low - arithPkg::HALF) << 1;
                            high <= lowerHalf ? high << 1 : (high - arithPkg::HALF) << 1;
                            pendingValue <= lowerHalf;
                            if (pending != '0) begin
                                state <= EMIT_PENDING;
                            end
                        end
                    end else if (middleHalf) begin
                        low <= (low - arithPkg::QUARTER) << 1;
                        high <= (high - arithPkg::QUARTER) << 1;
                        pending <= pending + 1'b1;
                    end else if (lastSymbol) begin
                        pending <= pending + 1'b1;      // one extra bit pins the final quarter
                        state <= EMIT_FINAL;
                    end else begin
                        state <= NEED_SYMBOL;
                    end
                end
                EMIT_FINAL: begin
                    if (accept) begin
                        pendingValue <= !bitValue;
                        flushing <= 1'b1;
                        state <= EMIT_PENDING;
                    end
                end
                EMIT_PENDING: begin
                    if (accept) begin
                        pending <= pending - 1'b1;
                        if (pending == 1) begin
                            state <= flushing ? DRAIN : SCALE;
                        end
                    end
                end
                default: begin
                    if (!bitStall) begin        // fresh interval for the next stream
                        low <= '0;
                        high <= arithPkg::WHOLE;
                        lastSymbol <= 1'b0;
                        flushing <= 1'b0;
                        state <= NEED_SYMBOL;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/intervalUpdate.sv */
// narrows the coding interval for one symbol, multiply then two divisions
`timescale 1ns/1ns
`default_nettype none

module intervalUpdate (
    input wire clk,
    input wire rstn,
    intervalIf.upd bus
);

    localparam int DIVIDEND_WIDTH = arithPkg::PRODUCT_BITS;
    localparam int DIVISOR_WIDTH = arithPkg::FREQ_BITS;

    typedef enum logic [1:0] {IDLE, MULTIPLY, DIV_HIGH, DIV_LOW} state_t;

    state_t state;
    arithPkg::bound_t base;
    arithPkg::bound_t span;
    arithPkg::freq_t lowCount;
    arithPkg::freq_t highCount;
    logic [DIVIDEND_WIDTH-1:0] lowProduct;
    logic [DIVIDEND_WIDTH-1:0] highProduct;
    logic [DIVIDEND_WIDTH-1:0] dividend;
    logic [DIVIDEND_WIDTH-DIVISOR_WIDTH-1:0] quotient;
    logic startDiv;
    logic doneDiv;

    freqModel i_freqModel (
        .clk,
        .symbol(bus.symbol),
        .lowCount,
        .highCount
    );

    // one divider, high product first
    assign dividend = (state == DIV_LOW) ? lowProduct : highProduct;

    seqDivider #(
        .DIVIDEND_WIDTH(DIVIDEND_WIDTH),
        .DIVISOR_WIDTH(DIVISOR_WIDTH)
    ) i_seqDivider (
        .clk,
        .rstn,
        .startDiv,
        .dividend,
        .divisor(arithPkg::TOTAL_FREQ),
        .quotient,
        .doneDiv
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            startDiv <= 1'b0;
            bus.done <= 1'b0;
        end else begin
            startDiv <= 1'b0;
            bus.done <= 1'b0;
            case (state)
                IDLE: begin
                    if (bus.go) begin       // counts are looked up on this edge
                        base <= bus.curLow;
                        span <= bus.curHigh - bus.curLow;
                        state <= MULTIPLY;
                    end
                end
                MULTIPLY: begin
                    highProduct <= span * highCount;
                    lowProduct <= span * lowCount;
                    startDiv <= 1'b1;
                    state <= DIV_HIGH;
                end
                DIV_HIGH: begin
                    if (doneDiv) begin
                        bus.high <= arithPkg::bound_t'(base + quotient);
                        startDiv <= 1'b1;
                        state <= DIV_LOW;
                    end
                end
                default: begin
                    if (doneDiv) begin
                        bus.low <= arithPkg::bound_t'(base + quotient);
                        bus.done <= 1'b1;
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/seqDivider.sv */
// restoring shift-subtract divider, one quotient bit per clock
`timescale 1ns/1ns
`default_nettype none

module seqDivider #(
    parameter int DIVIDEND_WIDTH = 25,
    parameter int DIVISOR_WIDTH = 7
) (
    input wire clk,
    input wire rstn,
    input wire startDiv,
    input wire [DIVIDEND_WIDTH-1:0] dividend,
    input wire [DIVISOR_WIDTH-1:0] divisor,
    output logic [DIVIDEND_WIDTH-DIVISOR_WIDTH-1:0] quotient,
    output logic doneDiv
);

    // top bits of the dividend must be below the divisor
    localparam int QUOT_WIDTH = DIVIDEND_WIDTH - DIVISOR_WIDTH;
    localparam int COUNT_BITS = $clog2(QUOT_WIDTH + 1);

    logic [DIVISOR_WIDTH-1:0] rem;
    logic [DIVISOR_WIDTH-1:0] remSrc;
    logic [QUOT_WIDTH-1:0] shiftReg;        // low dividend bits out, quotient bits in
    logic [QUOT_WIDTH-1:0] shiftSrc;
    logic [DIVISOR_WIDTH:0] trial;
    logic fits;
    logic [COUNT_BITS-1:0] count;
    logic busy;

    // the first step works straight from the operands
    always_comb begin
        remSrc = startDiv ? dividend[DIVIDEND_WIDTH-1:QUOT_WIDTH] : rem;
        shiftSrc = startDiv ? dividend[QUOT_WIDTH-1:0] : shiftReg;
        trial = {remSrc, shiftSrc[QUOT_WIDTH-1]};
        fits = trial >= {1'b0, divisor};
    end

    always_ff @(posedge clk) begin
        if (startDiv || busy) begin
            rem <= fits ? DIVISOR_WIDTH'(trial - {1'b0, divisor}) : trial[DIVISOR_WIDTH-1:0];
            shiftReg <= {shiftSrc[QUOT_WIDTH-2:0], fits};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            count <= '0;
            doneDiv <= 1'b0;
        end else begin
            doneDiv <= 1'b0;
            if (startDiv) begin
                busy <= 1'b1;
                count <= COUNT_BITS'(QUOT_WIDTH - 1);      // steps left after this one
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == COUNT_BITS'(1)) begin
                    busy <= 1'b0;
                    doneDiv <= 1'b1;
                end
            end
        end
    end

    assign quotient = shiftReg;     // holds until the next start

endmodule

`default_nettype wire

/* hdl/freqModel.sv */
// registered lookup of the cumulative counts bounding a symbol
`timescale 1ns/1ns
`default_nettype none

module freqModel (
    input wire clk,
    input wire arithPkg::symbol_t symbol,
    output arithPkg::freq_t lowCount,
    output arithPkg::freq_t highCount
);

    always_ff @(posedge clk) begin
        if (int'(symbol) < arithPkg::NUM_SYMBOLS) begin
            lowCount <= arithPkg::CUM_FREQ[int'(symbol)];
            highCount <= arithPkg::CUM_FREQ[int'(symbol) + 1];
        end else begin
            lowCount <= '0;     // codes past EOF get an empty range
            highCount <= '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/intervalIf.sv */
// one symbol's interval update request and result
`timescale 1ns/1ns
`default_nettype none

interface intervalIf;

    logic go;                       // single-cycle request
    arithPkg::bound_t curLow;       // interval before the symbol
    arithPkg::bound_t curHigh;
    arithPkg::symbol_t symbol;
    arithPkg::bound_t low;          // narrowed interval, valid with done
    arithPkg::bound_t high;
    logic done;

    modport upd (input go, curLow, curHigh, symbol, output low, high, done);
    modport ren (output go, curLow, curHigh, symbol, input low, high, done);

endinterface

`default_nettype wire

/* hdl/arithPkg.sv */
// arithmetic encoder constants, interval bounds, symbol model and shared types
`default_nettype none

package arithPkg;

    localparam int PRECISION = 18;          // interval precision in bits
    localparam int NUM_SYMBOLS = 5;
    localparam int EOF_SYMBOL = 4;
    localparam int SYM_BITS = 3;
    localparam int FREQ_BITS = 7;
    localparam int PRODUCT_BITS = PRECISION + FREQ_BITS;    // span times a count
    localparam int PENDING_BITS = 7;

    typedef logic [PRECISION-1:0] bound_t;
    typedef logic [SYM_BITS-1:0] symbol_t;
    typedef logic [FREQ_BITS-1:0] freq_t;

    localparam bound_t WHOLE = bound_t'(2 ** (PRECISION - 1));
    localparam bound_t HALF = bound_t'(2 ** (PRECISION - 2));
    localparam bound_t QUARTER = bound_t'(2 ** (PRECISION - 3));
    localparam bound_t THREE_QUARTERS = bound_t'(3 * 2 ** (PRECISION - 3));

    localparam freq_t TOTAL_FREQ = 61;

    // symbol k covers [CUM_FREQ[k], CUM_FREQ[k+1])
    localparam freq_t CUM_FREQ [NUM_SYMBOLS+1] = '{0, 20, 36, 51, 59, 61};

endpackage

`default_nettype wire
